// File: include/soc_macros.svh
// system-on-chip constants for bus widths, address map, reset and device table
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// bus widths
`define SOC_ARCHBITSZ 32
`define SOC_ADDRBITSZ 30

// address map in word addresses with one 4 KB window per slot
`define SOC_SLOT_LOG2 10
`define SOC_SLOT_COUNT 4

// reset sequencer
`define SOC_RST_CNTR_BITSZ 4

// scratch RAM depth as word-address bits
`define SOC_RAM_LOG2 8

// external interrupt sources
`define SOC_IRQ_SRC_COUNT 2

// device ids
`define SOC_ID_DEVTBL 7
`define SOC_ID_IRQCTRL 3
`define SOC_ID_RAM 1
`define SOC_ID_INVALID 0

// map sizes in bytes
`define SOC_MAPSZ_DEVTBL 4096
`define SOC_MAPSZ_IRQCTRL 4096
`define SOC_MAPSZ_RAM 1024
`define SOC_MAPSZ_INVALID 4096

// interrupt-use bit per slot
`define SOC_USEINTR_MASK 4'b0000

`endif

// File: src/soc_pkg.sv
// shared types of the system-on-chip: bus words, opcodes, slots and reset codes
`include "soc_macros.svh"

package soc_pkg;

	typedef logic [`SOC_ARCHBITSZ-1:0] word_t;
	typedef logic [`SOC_ADDRBITSZ-1:0] addr_t;
	typedef logic [(`SOC_ARCHBITSZ/8)-1:0] sel_t;

	typedef logic [`SOC_IRQ_SRC_COUNT-1:0] irq_src_t;

	// peripheral bus opcodes
	typedef enum logic [1:0] {
		PI1_NOP  = 2'b00,
		PI1_WR   = 2'b01,
		PI1_RD   = 2'b10,
		PI1_RDWR = 2'b11
	} pi1_op_e;

	// slot order follows word address bits 11:10
	typedef enum logic [1:0] {
		SLOT_DEVTBL  = 2'd0,
		SLOT_IRQCTRL = 2'd1,
		SLOT_RAM     = 2'd2,
		SLOT_INVALID = 2'd3
	} slot_e;

	// codes written to word 0 of the device table
	typedef enum logic [1:0] {
		SWRST_NONE     = 2'd0,
		SWRST_POWEROFF = 2'd1,
		SWRST_WARM     = 2'd2,
		SWRST_COLD     = 2'd3
	} swrst_e;

endpackage

// File: src/pi1_if.sv
// peripheral bus link between one master and one slave
`timescale 1ns/1ps

interface pi1_if;

	import soc_pkg::*;

	pi1_op_e op;
	addr_t addr;
	word_t wdata;
	word_t rdata;
	sel_t sel;
	logic rdy;

	modport master (
		output op,
		output addr,
		output wdata,
		output sel,
		input rdata,
		input rdy
	);

	modport slave (
		input op,
		input addr,
		input wdata,
		input sel,
		output rdata,
		output rdy
	);

endinterface

// File: src/pi1_router.sv
// single-master bus router that decodes the slot and answers invalid addresses
`timescale 1ns/1ps
`include "soc_macros.svh"

module pi1_router (
	input logic clk120mhz,
	input logic rst_p,
	pi1_if.slave m,
	pi1_if.master s_devtbl,
	pi1_if.master s_irqctrl,
	pi1_if.master s_ram
);

	import soc_pkg::*;

	localparam int SLOT_W = $clog2(`SOC_SLOT_COUNT);

	slot_e slot;
	logic bus_en_q;

	// anything above the slot bits falls through to the default slave
	always_comb begin
		if (|m.addr[`SOC_ADDRBITSZ-1:`SOC_SLOT_LOG2+SLOT_W])
			slot = SLOT_INVALID;
		else
			slot = slot_e'(m.addr[`SOC_SLOT_LOG2+SLOT_W-1:`SOC_SLOT_LOG2]);
	end

	// default slave stays silent until the system leaves reset
	always_ff @(posedge clk120mhz) begin
		if (rst_p)
			bus_en_q <= 1'b0;
		else
			bus_en_q <= 1'b1;
	end

	assign s_devtbl.op = (slot == SLOT_DEVTBL) ? m.op : PI1_NOP;
	assign s_devtbl.addr = m.addr;
	assign s_devtbl.wdata = m.wdata;
	assign s_devtbl.sel = m.sel;

	assign s_irqctrl.op = (slot == SLOT_IRQCTRL) ? m.op : PI1_NOP;
	assign s_irqctrl.addr = m.addr;
	assign s_irqctrl.wdata = m.wdata;
	assign s_irqctrl.sel = m.sel;

	assign s_ram.op = (slot == SLOT_RAM) ? m.op : PI1_NOP;
	assign s_ram.addr = m.addr;
	assign s_ram.wdata = m.wdata;
	assign s_ram.sel = m.sel;

	// response mux, no added cycle
	always_comb begin
		case (slot)
			SLOT_DEVTBL: begin
				m.rdata = s_devtbl.rdata;
				m.rdy = s_devtbl.rdy;
			end
			SLOT_IRQCTRL: begin
				m.rdata = s_irqctrl.rdata;
				m.rdy = s_irqctrl.rdy;
			end
			SLOT_RAM: begin
				m.rdata = s_ram.rdata;
				m.rdy = s_ram.rdy;
			end
			default: begin
				m.rdata = '0;
				m.rdy = (m.op != PI1_NOP) && bus_en_q;
			end
		endcase
	end

	// a slave never completes a transfer the master has not kept up
	a_rdy_needs_op: assert property (
		@(posedge clk120mhz) disable iff (rst_p)
		m.rdy |-> (m.op != PI1_NOP)
	);

endmodule

// File: src/reset_ctrl.sv
// system reset sequencer with reload counter and power-off latch
`timescale 1ns/1ps
`include "soc_macros.svh"

module reset_ctrl (
	input logic clk120mhz,
	input logic rst_p,
	input soc_pkg::swrst_e swrst_i,
	output logic sys_rst_o
);

	import soc_pkg::*;

	logic [`SOC_RST_CNTR_BITSZ-1:0] rst_cntr_q;
	logic pwroff_q;
	logic pwroff_d;
	logic reload;
	logic sys_rst_q;

	// cold and warm behave alike without a global set/reset
	assign reload = rst_p || (swrst_i == SWRST_WARM) || (swrst_i == SWRST_COLD);

	// only the board reset leaves power-off
	assign pwroff_d = rst_p ? 1'b0 : (pwroff_q || (swrst_i == SWRST_POWEROFF));

	always_ff @(posedge clk120mhz) begin
		if (reload)
			rst_cntr_q <= {`SOC_RST_CNTR_BITSZ{1'b1}};
		else if (rst_cntr_q != '0)
			rst_cntr_q <= rst_cntr_q - 1'b1;
	end

	// registered so that release lands 15 cycles after rst_p is seen low
	always_ff @(posedge clk120mhz) begin
		pwroff_q <= pwroff_d;
		sys_rst_q <= reload || (rst_cntr_q != '0) || pwroff_d;
	end

	assign sys_rst_o = sys_rst_q;

	a_rst_follows_board: assert property (
		@(posedge clk120mhz) rst_p |=> sys_rst_o
	);

endmodule

// File: src/dev_table.sv
// device table slave listing every slot, plus the software reset control word
`timescale 1ns/1ps
`include "soc_macros.svh"

module dev_table (
	input logic clk120mhz,
	input logic rst_p,
	pi1_if.slave bus,
	output soc_pkg::swrst_e swrst_o
);

	import soc_pkg::*;

	localparam int SLOT_W = $clog2(`SOC_SLOT_COUNT);

	localparam word_t DEV_ID [`SOC_SLOT_COUNT] = '{
		`SOC_ID_DEVTBL, `SOC_ID_IRQCTRL, `SOC_ID_RAM, `SOC_ID_INVALID
	};
	localparam word_t DEV_MAPSZ [`SOC_SLOT_COUNT] = '{
		`SOC_MAPSZ_DEVTBL, `SOC_MAPSZ_IRQCTRL, `SOC_MAPSZ_RAM, `SOC_MAPSZ_INVALID
	};
	localparam logic [`SOC_SLOT_COUNT-1:0] USEINTR = `SOC_USEINTR_MASK;

	logic [`SOC_SLOT_LOG2-1:0] word_idx;
	logic [`SOC_SLOT_LOG2-1:0] entry;
	logic [SLOT_W-1:0] k;
	word_t rd_word;
	word_t rdata_q;
	logic rdy_q;
	logic accept;
	logic wr_op;

	assign word_idx = bus.addr[`SOC_SLOT_LOG2-1:0];
	assign accept = (bus.op != PI1_NOP) && !rdy_q;
	assign wr_op = (bus.op == PI1_WR) || (bus.op == PI1_RDWR);

	// word 1+2k holds the id of slot k, word 2+2k its map size
	assign entry = word_idx - 1'b1;
	assign k = entry[SLOT_W:1];

	always_comb begin
		rd_word = '0;
		if (word_idx == '0)
			rd_word = `SOC_SLOT_COUNT;
		else if (word_idx <= 2 * `SOC_SLOT_COUNT) begin
			if (word_idx[0])
				rd_word = DEV_ID[k];
			else
				rd_word = DEV_MAPSZ[k] | {USEINTR[k], {(`SOC_ARCHBITSZ-1){1'b0}}};
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (rst_p)
			rdy_q <= 1'b0;
		else
			rdy_q <= accept;
	end

	always_ff @(posedge clk120mhz) begin
		if (accept)
			rdata_q <= rd_word;
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy = rdy_q;

	// code is valid only in the completing cycle of a write to word 0
	assign swrst_o = (rdy_q && wr_op && (word_idx == '0)) ?
		swrst_e'(bus.wdata[1:0]) : SWRST_NONE;

endmodule

// File: src/irq_ctrl.sv
// interrupt controller funnelling the external sources to one destination
`timescale 1ns/1ps
`include "soc_macros.svh"

module irq_ctrl (
	input logic clk120mhz,
	input logic rst_p,
	pi1_if.slave bus,
	input soc_pkg::irq_src_t irq_src_i,
	output logic irq_req_o,
	input logic irq_ack_i
);

	import soc_pkg::*;

	localparam int IDX_W = $clog2(`SOC_IRQ_SRC_COUNT);

	// four-phase handshake towards the destination
	typedef enum logic [1:0] {
		IRQ_IDLE,
		IRQ_REQ,
		IRQ_DONE
	} irq_state_e;

	irq_state_e state_q;
	irq_src_t pend_q;
	irq_src_t clr;
	logic [IDX_W-1:0] low_idx;
	logic [IDX_W-1:0] last_q;
	logic [`SOC_SLOT_LOG2-1:0] word_idx;
	word_t rd_word;
	word_t rdata_q;
	logic rdy_q;
	logic accept;
	logic served;

	// lowest index wins
	always_comb begin
		low_idx = '0;
		for (int i = `SOC_IRQ_SRC_COUNT - 1; i >= 0; i--) begin
			if (pend_q[i])
				low_idx = IDX_W'(i);
		end
	end

	assign served = (state_q == IRQ_REQ) && irq_ack_i;

	always_comb begin
		clr = '0;
		if (served)
			clr[low_idx] = 1'b1;
	end

	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			state_q <= IRQ_IDLE;
			pend_q <= '0;
			last_q <= '0;
		end else begin
			// a source pulsing in the clearing cycle stays pending
			pend_q <= (pend_q & ~clr) | irq_src_i;
			case (state_q)
				IRQ_IDLE: begin
					if (|pend_q)
						state_q <= IRQ_REQ;
				end
				IRQ_REQ: begin
					if (irq_ack_i) begin
						last_q <= low_idx;
						state_q <= IRQ_DONE;
					end
				end
				default: begin
					// wait for the ack to fall before asking again
					if (!irq_ack_i)
						state_q <= (|pend_q) ? IRQ_REQ : IRQ_IDLE;
				end
			endcase
		end
	end

	assign irq_req_o = (state_q == IRQ_REQ);

	// status readback, writes have no effect
	assign word_idx = bus.addr[`SOC_SLOT_LOG2-1:0];
	assign accept = (bus.op != PI1_NOP) && !rdy_q;

	always_comb begin
		case (word_idx)
			'd0: rd_word = word_t'(last_q);
			'd1: rd_word = word_t'(pend_q);
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk120mhz) begin
		if (rst_p)
			rdy_q <= 1'b0;
		else
			rdy_q <= accept;
	end

	always_ff @(posedge clk120mhz) begin
		if (accept)
			rdata_q <= rd_word;
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy = rdy_q;

	a_req_held_until_ack: assert property (
		@(posedge clk120mhz) disable iff (rst_p)
		$fell(irq_req_o) |-> $past(irq_ack_i)
	);

endmodule

// File: src/scratch_ram.sv
// 256-word scratch RAM slave with byte selects and swap
`timescale 1ns/1ps
`include "soc_macros.svh"

module scratch_ram (
	input logic clk120mhz,
	input logic rst_p,
	pi1_if.slave bus
);

	import soc_pkg::*;

	localparam int DEPTH = 1 << `SOC_RAM_LOG2;
	localparam int BYTES = `SOC_ARCHBITSZ / 8;

	word_t mem [DEPTH];
	logic [`SOC_RAM_LOG2-1:0] idx;
	word_t rdata_q;
	logic rdy_q;
	logic accept;
	logic wr_en;

	// upper address bits ignored so the RAM repeats through its window
	assign idx = bus.addr[`SOC_RAM_LOG2-1:0];
	assign accept = (bus.op != PI1_NOP) && !rdy_q;
	assign wr_en = accept && !rst_p && ((bus.op == PI1_WR) || (bus.op == PI1_RDWR));

	always_ff @(posedge clk120mhz) begin
		if (rst_p)
			rdy_q <= 1'b0;
		else
			rdy_q <= accept;
	end

	// swap reads the old word at the same edge the new bytes land
	always_ff @(posedge clk120mhz) begin
		if (accept)
			rdata_q <= mem[idx];
		if (wr_en) begin
			for (int b = 0; b < BYTES; b++) begin
				if (bus.sel[b])
					mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
			end
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy = rdy_q;

endmodule

// File: src/soc_top.sv
// system-on-chip top level joining the bus router, slaves and reset sequencer
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_top (
	input logic clk120mhz,
	input logic rst_p,
	input logic [1:0] pi1_op_i,
	input logic [`SOC_ADDRBITSZ-1:0] pi1_addr_i,
	input logic [`SOC_ARCHBITSZ-1:0] pi1_data_i,
	input logic [(`SOC_ARCHBITSZ/8)-1:0] pi1_sel_i,
	output logic [`SOC_ARCHBITSZ-1:0] pi1_data_o,
	output logic pi1_rdy_o,
	input logic [`SOC_IRQ_SRC_COUNT-1:0] irq_src_i,
	output logic irq_req_o,
	input logic irq_ack_i,
	output logic sys_rst_o
);

	import soc_pkg::*;

	logic sys_rst;
	swrst_e swrst;

	pi1_if m_bus ();
	pi1_if devtbl_bus ();
	pi1_if irqctrl_bus ();
	pi1_if ram_bus ();

	// master side comes straight from the pins
	assign m_bus.op = pi1_op_e'(pi1_op_i);
	assign m_bus.addr = pi1_addr_i;
	assign m_bus.wdata = pi1_data_i;
	assign m_bus.sel = pi1_sel_i;
	assign pi1_data_o = m_bus.rdata;
	assign pi1_rdy_o = m_bus.rdy;

	assign sys_rst_o = sys_rst;

	reset_ctrl u_reset_ctrl (
		.clk120mhz (clk120mhz),
		.rst_p     (rst_p),
		.swrst_i   (swrst),
		.sys_rst_o (sys_rst)
	);

	pi1_router u_router (
		.clk120mhz (clk120mhz),
		.rst_p     (sys_rst),
		.m         (m_bus.slave),
		.s_devtbl  (devtbl_bus.master),
		.s_irqctrl (irqctrl_bus.master),
		.s_ram     (ram_bus.master)
	);

	dev_table u_dev_table (
		.clk120mhz (clk120mhz),
		.rst_p     (sys_rst),
		.bus       (devtbl_bus.slave),
		.swrst_o   (swrst)
	);

	irq_ctrl u_irq_ctrl (
		.clk120mhz (clk120mhz),
		.rst_p     (sys_rst),
		.bus       (irqctrl_bus.slave),
		.irq_src_i (irq_src_i),
		.irq_req_o (irq_req_o),
		.irq_ack_i (irq_ack_i)
	);

	scratch_ram u_scratch_ram (
		.clk120mhz (clk120mhz),
		.rst_p     (sys_rst),
		.bus       (ram_bus.slave)
	);

endmodule

// File: test/tb_soc.sv
// soc glue testbench covering reset, device table, RAM, interrupts and software reset
`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc;

	import soc_pkg::*;

	localparam int BUS_TIMEOUT = 16;
	localparam int IRQ_TIMEOUT = 32;
	localparam int RST_TIMEOUT = 64;
	localparam addr_t DEVTBL_BASE = addr_t'(0);
	localparam addr_t IRQ_BASE = addr_t'(1) << `SOC_SLOT_LOG2;
	localparam addr_t RAM_BASE = addr_t'(2) << `SOC_SLOT_LOG2;

	// one completed transfer as seen at the master port
	typedef struct packed {
		logic [1:0] op;
		addr_t addr;
		word_t wdata;
		sel_t sel;
		word_t rdata;
		logic [7:0] lat;
	} xfer_t;

	logic clk120mhz = 1'b0;
	logic rst_p;
	logic [1:0] pi1_op_i;
	addr_t pi1_addr_i;
	word_t pi1_data_i;
	sel_t pi1_sel_i;
	word_t pi1_data_o;
	logic pi1_rdy_o;
	irq_src_t irq_src_i;
	logic irq_req_o;
	logic irq_ack_i;
	logic sys_rst_o;

	// reference state
	word_t ram_model [1 << `SOC_RAM_LOG2];
	irq_src_t pend_model;
	int last_model;

	xfer_t xfer_q [$];
	logic [31:0] lfsr_q = 32'hf1861ad2;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_err0 = 0;

	soc_top i_dut (
		.clk120mhz  (clk120mhz),
		.rst_p      (rst_p),
		.pi1_op_i   (pi1_op_i),
		.pi1_addr_i (pi1_addr_i),
		.pi1_data_i (pi1_data_i),
		.pi1_sel_i  (pi1_sel_i),
		.pi1_data_o (pi1_data_o),
		.pi1_rdy_o  (pi1_rdy_o),
		.irq_src_i  (irq_src_i),
		.irq_req_o  (irq_req_o),
		.irq_ack_i  (irq_ack_i),
		.sys_rst_o  (sys_rst_o)
	);

	always #10 clk120mhz = ~clk120mhz;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// every byte depends on the full RAM index
	function automatic word_t fill_word(input int i);
		logic [7:0] b;
		b = 8'(i);
		return {b ^ 8'ha5, ~b, b, b + 8'h3c};
	endfunction

	// slot 3 and anything above bit 11 is the default slave
	function automatic int ref_slot(input addr_t a);
		if (a[`SOC_ADDRBITSZ-1:12] != '0)
			return 3;
		return int'(a[11:10]);
	endfunction

	// the lowest pending source is served first
	function automatic int lowest_pending(input irq_src_t p);
		int j;
		j = 0;
		while (j < `SOC_IRQ_SRC_COUNT - 1 && !p[j])
			j++;
		return j;
	endfunction

	function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input sel_t sel);
		word_t r;
		r = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				r[8*b +: 8] = new_w[8*b +: 8];
		end
		return r;
	endfunction

	// expected read data for any address in the current model state
	function automatic word_t ref_read(input addr_t a);
		logic [3:0] use_mask;
		int w;
		int k;
		word_t r;
		use_mask = `SOC_USEINTR_MASK;
		w = int'(a[9:0]);
		k = (w - 1) / 2;
		r = '0;
		case (ref_slot(a))
			0: begin
				if (w == 0)
					r = `SOC_SLOT_COUNT;
				else if (w <= 2 * `SOC_SLOT_COUNT) begin
					case (k)
						0: r = (w % 2) ? `SOC_ID_DEVTBL : `SOC_MAPSZ_DEVTBL;
						1: r = (w % 2) ? `SOC_ID_IRQCTRL : `SOC_MAPSZ_IRQCTRL;
						2: r = (w % 2) ? `SOC_ID_RAM : `SOC_MAPSZ_RAM;
						default: r = (w % 2) ? `SOC_ID_INVALID : `SOC_MAPSZ_INVALID;
					endcase
					// map-size words carry the interrupt-use flag
					if (w % 2 == 0)
						r[31] = use_mask[k];
				end
			end
			1: begin
				if (w == 0)
					r = word_t'(last_model);
				else if (w == 1)
					r = word_t'(pend_model);
			end
			2: r = ram_model[a[`SOC_RAM_LOG2-1:0]];
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic report_value(input string sig, input word_t exp, input word_t got);
		$display("[FAIL] %s expected %h got %h", sig, exp, got);
		errors++;
	endtask

	// checks every completed transfer and keeps the RAM model current
	always @(negedge clk120mhz) begin : compare
		xfer_t x;
		word_t exp;
		int exp_lat;
		int idx;
		while (xfer_q.size() > 0) begin
			x = xfer_q.pop_front();
			exp = ref_read(x.addr);
			exp_lat = (ref_slot(x.addr) == 3) ? 0 : 1;
			idx = int'(x.addr[`SOC_RAM_LOG2-1:0]);
			checks++;
			if (x.lat != exp_lat)
				report_value($sformatf("pi1_rdy_o latency at %h", x.addr), exp_lat, x.lat);
			if (x.op == PI1_RD || x.op == PI1_RDWR) begin
				checks++;
				if (x.rdata !== exp)
					report_value($sformatf("pi1_data_o at %h", x.addr), exp, x.rdata);
			end
			// swap has already read the old word
			if ((x.op == PI1_WR || x.op == PI1_RDWR) && ref_slot(x.addr) == 2)
				ram_model[idx] = merge_bytes(ram_model[idx], x.wdata, x.sel);
		end
	end

	task automatic bus_xfer(input pi1_op_e op, input addr_t a, input word_t d, input sel_t s);
		xfer_t x;
		int lat;
		bit done;
		lat = 0;
		done = 1'b0;
		@(posedge clk120mhz);
		pi1_op_i <= op;
		pi1_addr_i <= a;
		pi1_data_i <= d;
		pi1_sel_i <= s;
		while (!done && lat < BUS_TIMEOUT) begin
			@(negedge clk120mhz);
			if (pi1_rdy_o) begin
				done = 1'b1;
				x = {op, a, d, s, pi1_data_o, 8'(lat)};
				xfer_q.push_back(x);
			end else begin
				lat++;
			end
		end
		@(posedge clk120mhz);
		pi1_op_i <= PI1_NOP;
		if (!done) begin
			$display("bus op %0d at %h got no ready within %0d cycles", op, a, BUS_TIMEOUT);
			errors++;
		end
	endtask

	task automatic read_word(input addr_t a);
		bus_xfer(PI1_RD, a, '0, '0);
	endtask

	task automatic write_word(input addr_t a, input word_t d, input sel_t s);
		bus_xfer(PI1_WR, a, d, s);
	endtask

	// sys_rst_o follows rst_p for the rest of the five reset cycles
	task automatic hold_reset();
		repeat (4) begin
			@(posedge clk120mhz);
			@(negedge clk120mhz);
			checks++;
			if (sys_rst_o !== 1'b1)
				report_value("sys_rst_o", 1, sys_rst_o);
		end
		@(posedge clk120mhz);
		rst_p <= 1'b0;
	endtask

	// counts edges from the first one that samples rst_p low
	task automatic measure_release();
		int n;
		bit done;
		n = 0;
		done = 1'b0;
		@(posedge clk120mhz);
		while (!done && n < RST_TIMEOUT) begin
			@(posedge clk120mhz);
			n++;
			@(negedge clk120mhz);
			checks++;
			if (pi1_rdy_o !== 1'b0)
				report_value("pi1_rdy_o", 0, pi1_rdy_o);
			if (irq_req_o !== 1'b0)
				report_value("irq_req_o", 0, irq_req_o);
			if (sys_rst_o === 1'b0)
				done = 1'b1;
		end
		checks++;
		if (!done) begin
			$display("sys_rst_o did not fall within %0d cycles of reset release", RST_TIMEOUT);
			errors++;
		end else if (n != 15) begin
			report_value("sys_rst_o release cycles", 15, n);
		end
		pend_model = '0;
		last_model = 0;
	endtask

	task automatic wait_sys_rst(input logic level, input int limit);
		int n;
		n = 0;
		while (sys_rst_o !== level && n < limit) begin
			@(negedge clk120mhz);
			n++;
		end
		if (sys_rst_o !== level) begin
			$display("sys_rst_o did not reach %0b within %0d cycles", level, limit);
			errors++;
		end
	endtask

	task automatic wait_irq_req(input logic level);
		int n;
		n = 0;
		while (irq_req_o !== level && n < IRQ_TIMEOUT) begin
			@(negedge clk120mhz);
			n++;
		end
		if (irq_req_o !== level) begin
			$display("irq_req_o did not reach %0b within %0d cycles", level, IRQ_TIMEOUT);
			errors++;
		end
	endtask

	task automatic pulse_sources(input irq_src_t v);
		@(posedge clk120mhz);
		irq_src_i <= v;
		@(posedge clk120mhz);
		irq_src_i <= '0;
	endtask

	task automatic end_test(input string name);
		int n;
		repeat (2) @(negedge clk120mhz);
		n = errors - test_err0;
		tests++;
		$display("test %0d %s: %s, %0d errors", tests, name, (n == 0) ? "ok" : "failed", n);
		test_err0 = errors;
	endtask

	initial begin : main
		addr_t hi;
		irq_src_t v1;
		irq_src_t v2;
		word_t d;
		sel_t s;
		logic [1:0] bank;
		int idx;
		int n;
		rst_p = 1'b1;
		pi1_op_i = PI1_NOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i = '0;
		irq_src_i = '0;
		irq_ack_i = 1'b0;
		pend_model = '0;
		last_model = 0;

		hold_reset();
		measure_release();
		end_test("reset");

		// includes words past the last entry
		for (int w = 0; w < 12; w++)
			read_word(DEVTBL_BASE + addr_t'(w));
		end_test("device table");

		for (int i = 0; i < 256; i++)
			write_word(RAM_BASE + addr_t'(i), fill_word(i), 4'hf);
		for (int i = 0; i < 32; i++) begin
			idx = int'(rand_bits(8));
			d = rand_bits(32);
			s = sel_t'(rand_bits(4));
			write_word(RAM_BASE + addr_t'(idx), d, s);
			bank = 2'(rand_bits(2));
			read_word(RAM_BASE + (addr_t'(bank) << 8) + addr_t'(idx));
		end
		for (int i = 0; i < 16; i++) begin
			idx = int'(rand_bits(8));
			d = rand_bits(32);
			s = sel_t'(rand_bits(4));
			bus_xfer(PI1_RDWR, RAM_BASE + addr_t'(idx), d, s);
			read_word(RAM_BASE + addr_t'(idx));
		end
		// a word 256 words higher is the same word
		for (int i = 0; i < 8; i++) begin
			idx = int'(rand_bits(8));
			read_word(RAM_BASE + addr_t'(idx));
			read_word(RAM_BASE + addr_t'(idx) + 30'd256);
		end
		end_test("scratch ram");

		for (int i = 0; i < 8; i++) begin
			idx = int'(rand_bits(8));
			hi = addr_t'(rand_bits(18)) << 12;
			if (hi == '0)
				hi = addr_t'(1) << 12;
			read_word((addr_t'(3) << 10) | addr_t'(rand_bits(10)));
			read_word(hi | RAM_BASE | addr_t'(idx));
			write_word((addr_t'(3) << 10) | addr_t'(idx), rand_bits(32), 4'hf);
			// would hit the RAM if the high bits were ignored
			write_word(hi | RAM_BASE | addr_t'(idx), rand_bits(32), 4'hf);
			read_word(RAM_BASE + addr_t'(idx));
		end
		end_test("invalid slot");

		for (int r = 0; r < 4; r++) begin
			v1 = irq_src_t'(rand_bits(2));
			v2 = irq_src_t'(rand_bits(2));
			if ((v1 | v2) == '0)
				v1 = 2'b01;
			pulse_sources(v1);
			pulse_sources(v2);
			pend_model = pend_model | v1 | v2;
			n = 0;
			while (pend_model != '0 && n < 4) begin
				wait_irq_req(1'b1);
				@(posedge clk120mhz);
				irq_ack_i <= 1'b1;
				wait_irq_req(1'b0);
				last_model = lowest_pending(pend_model);
				pend_model[last_model] = 1'b0;
				@(posedge clk120mhz);
				irq_ack_i <= 1'b0;
				read_word(IRQ_BASE);
				read_word(IRQ_BASE + 30'd1);
				n++;
			end
		end
		repeat (4) begin
			@(negedge clk120mhz);
			checks++;
			if (irq_req_o !== 1'b0)
				report_value("irq_req_o", 0, irq_req_o);
		end
		end_test("interrupts");

		write_word(DEVTBL_BASE, word_t'(SWRST_WARM), 4'hf);
		wait_sys_rst(1'b1, 8);
		wait_sys_rst(1'b0, RST_TIMEOUT);
		pend_model = '0;
		last_model = 0;
		for (int i = 0; i < 8; i++)
			read_word(RAM_BASE + addr_t'(rand_bits(8)));
		read_word(IRQ_BASE);
		// power-off holds the system until the board reset
		write_word(DEVTBL_BASE, word_t'(SWRST_POWEROFF), 4'hf);
		wait_sys_rst(1'b1, 8);
		// a held invalid-slot read gets no ready while the system is in reset
		@(posedge clk120mhz);
		pi1_op_i <= PI1_RD;
		pi1_addr_i <= addr_t'(3) << 10;
		for (int i = 0; i < 100; i++) begin
			@(negedge clk120mhz);
			checks++;
			if (sys_rst_o !== 1'b1)
				report_value("sys_rst_o", 1, sys_rst_o);
			if (pi1_rdy_o !== 1'b0)
				report_value("pi1_rdy_o", 0, pi1_rdy_o);
		end
		@(posedge clk120mhz);
		pi1_op_i <= PI1_NOP;
		rst_p <= 1'b1;
		hold_reset();
		measure_release();
		for (int i = 0; i < 8; i++)
			read_word(RAM_BASE + addr_t'(rand_bits(8)));
		end_test("software reset");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: build.f
+incdir+include
src/soc_pkg.sv
src/pi1_if.sv
src/pi1_router.sv
src/reset_ctrl.sv
src/dev_table.sv
src/irq_ctrl.sv
src/scratch_ram.sv
src/soc_top.sv
test/tb_soc.sv

// File: Bender.yml
package:
  name: soc_glue

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/soc_pkg.sv
      - src/pi1_if.sv
      - src/pi1_router.sv
      - src/reset_ctrl.sv
      - src/dev_table.sv
      - src/irq_ctrl.sv
      - src/scratch_ram.sv
      - src/soc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_soc.sv
